/* ex_settings.svh */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// widths of the execute stage datapath
`define EX_XLEN 64
`define EX_ILEN 32
`define EX_REG_AW 5

// branch immediate holds imm[12:1]
`define EX_BIMM_W 12

`define EX_MUL_CYCLES 64 // one multiplier bit per cycle
`define EX_OPC_BRANCH 7'b1100011 // major opcode of conditional branches

`endif

/* ex_op_pkg.sv */
package ex_op_pkg;

	// numbering follows the decode stage encoding
	typedef enum logic [4:0] {
		op_add = 5'd0, op_addw = 5'd1,
		op_sll = 5'd2, op_sllw = 5'd3,
		op_sra = 5'd4, op_sraw = 5'd5,
		op_srl = 5'd6, op_srlw = 5'd7,
		op_and = 5'd8, op_or = 5'd9, op_xor = 5'd10,
		op_slt = 5'd11, op_sltu = 5'd12,
		op_eq = 5'd13, op_ne = 5'd14,
		op_ge = 5'd15, op_geu = 5'd16,
		op_sub = 5'd17, op_subw = 5'd18,
		op_mul = 5'd19, op_mulh = 5'd20, op_mulhu = 5'd21, op_mulw = 5'd22
	} ex_op_e;

	typedef struct packed {
		logic word; // low 32 bits sign extended
		logic ss; // signed times signed
		logic high; // upper half of the product
	} mul_ctrl_t;

	function automatic logic is_mul_op(input ex_op_e op);
		return op inside {op_mul, op_mulh, op_mulhu, op_mulw};
	endfunction

	function automatic mul_ctrl_t mul_decode(input ex_op_e op);
		mul_ctrl_t c;
		c = '0;
		case (op)
			op_mulh: begin
				c.ss = 1'b1;
				c.high = 1'b1;
			end
			op_mulhu: c.high = 1'b1;
			op_mulw: begin
				c.word = 1'b1;
				c.ss = 1'b1;
			end
			default: c = '0; // op_mul is plain low half
		endcase
		return c;
	endfunction

endpackage

/* ex_stage_pkg.sv */
`include "ex_settings.svh"

package ex_stage_pkg;

	// decode to execute
	typedef struct packed {
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_ILEN-1:0] ins;
		ex_op_pkg::ex_op_e op;
		logic [`EX_XLEN-1:0] src_a;
		logic [`EX_XLEN-1:0] src_b;
		logic [`EX_XLEN-1:0] rt_data; // store data
		logic brch;
		logic [`EX_BIMM_W:1] bimm;
		logic mem_w_en;
		logic wb_sel; // 0 result 1 memory data
		logic reg_w_en;
		logic [`EX_REG_AW-1:0] rdest;
	} ex_in_t;

	// execute to memory
	typedef struct packed {
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_ILEN-1:0] ins;
		logic mem_w_en;
		logic wb_sel;
		logic reg_w_en;
		logic [`EX_XLEN-1:0] rt_data;
		logic [`EX_REG_AW-1:0] rdest;
		logic [`EX_XLEN-1:0] result;
	} ex_out_t;

	// toward fetch
	typedef struct packed {
		logic taken;
		logic bubble; // kill the slot behind a branch
		logic [`EX_XLEN-1:0] target;
	} branch_t;

endpackage

/* ex_alu.sv */
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_alu (
	input ex_op_pkg::ex_op_e op,
	input logic [`EX_XLEN-1:0] src_a,
	input logic [`EX_XLEN-1:0] src_b,
	output logic [`EX_XLEN-1:0] alu_result
);
	import ex_op_pkg::*;

	localparam int word_w = 32;
	localparam int sh_w = $clog2(`EX_XLEN);
	localparam int sh_w_word = $clog2(word_w);

	logic [word_w-1:0] a_w;
	logic [word_w-1:0] b_w;
	logic [word_w-1:0] add_w;
	logic [word_w-1:0] sub_w;
	logic [word_w-1:0] sll_w;
	logic [word_w-1:0] srl_w;
	logic [word_w-1:0] sra_w;
	logic [sh_w-1:0] shamt;
	logic [sh_w_word-1:0] shamt_w;

	function automatic logic [`EX_XLEN-1:0] sext_w(input logic [word_w-1:0] v);
		return {{(`EX_XLEN-word_w){v[word_w-1]}}, v};
	endfunction

	function automatic logic [`EX_XLEN-1:0] flag(input logic c);
		return {{(`EX_XLEN-1){1'b0}}, c};
	endfunction

	assign a_w = src_a[word_w-1:0];
	assign b_w = src_b[word_w-1:0];
	assign shamt = src_b[sh_w-1:0];
	assign shamt_w = src_b[sh_w_word-1:0];

	// word forms work on the low half only
	assign add_w = a_w + b_w;
	assign sub_w = a_w - b_w;
	assign sll_w = a_w << shamt_w;
	assign srl_w = a_w >> shamt_w;
	assign sra_w = $signed(a_w) >>> shamt_w;

	always_comb begin
		case (op)
			op_add: alu_result = src_a + src_b;
			op_addw: alu_result = sext_w(add_w);
			op_sll: alu_result = src_a << shamt;
			op_sllw: alu_result = sext_w(sll_w);
			op_sra: alu_result = $signed(src_a) >>> shamt;
			op_sraw: alu_result = sext_w(sra_w);
			op_srl: alu_result = src_a >> shamt;
			op_srlw: alu_result = sext_w(srl_w);
			op_and: alu_result = src_a & src_b;
			op_or: alu_result = src_a | src_b;
			op_xor: alu_result = src_a ^ src_b;
			op_slt: alu_result = flag($signed(src_a) < $signed(src_b));
			op_sltu: alu_result = flag(src_a < src_b);
			op_eq: alu_result = flag(src_a == src_b);
			op_ne: alu_result = flag(src_a != src_b);
			op_ge: alu_result = flag($signed(src_a) >= $signed(src_b));
			op_geu: alu_result = flag(src_a >= src_b);
			op_sub: alu_result = src_a - src_b;
			op_subw: alu_result = sext_w(sub_w);
			default: alu_result = '0; // multiplies come from ex_mul
		endcase
	end

endmodule

/* ex_mul.sv */
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_mul (
	input logic clk,
	input logic reset,
	input logic start,
	input ex_op_pkg::mul_ctrl_t ctrl,
	input logic [`EX_XLEN-1:0] mul_a,
	input logic [`EX_XLEN-1:0] mul_b,
	output logic done,
	output logic [`EX_XLEN-1:0] product
);
	import ex_op_pkg::*;

	localparam int cnt_w = $clog2(`EX_MUL_CYCLES);
	localparam int word_w = 32;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_finish
	} state_e;

	state_e state;
	logic [cnt_w-1:0] cnt;
	mul_ctrl_t ctrl_q;
	logic neg_q;
	logic [`EX_XLEN-1:0] a_mag;
	logic [`EX_XLEN-1:0] b_mag;
	logic [`EX_XLEN-1:0] mcand;
	logic [2*`EX_XLEN-1:0] acc;
	logic [`EX_XLEN:0] partial;
	logic [2*`EX_XLEN-1:0] full;

	// magnitudes only for the signed form
	assign a_mag = (ctrl.ss && mul_a[`EX_XLEN-1]) ? -mul_a : mul_a;
	assign b_mag = (ctrl.ss && mul_b[`EX_XLEN-1]) ? -mul_b : mul_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_run;
						cnt <= '0;
					end
				end
				st_run: begin
					cnt <= cnt + 1'b1;
					if (cnt == cnt_w'(`EX_MUL_CYCLES - 1))
						state <= st_finish;
				end
				default: state <= st_idle; // finish lasts one cycle
			endcase
		end
	end

	// multiplier sits in the low half and shifts out one bit per step
	assign partial = {1'b0, acc[2*`EX_XLEN-1:`EX_XLEN]} + (acc[0] ? {1'b0, mcand} : '0);

	always_ff @(posedge clk) begin
		if (start && state == st_idle) begin
			ctrl_q <= ctrl;
			neg_q <= ctrl.ss && (mul_a[`EX_XLEN-1] ^ mul_b[`EX_XLEN-1]);
			mcand <= a_mag;
			acc <= {{`EX_XLEN{1'b0}}, b_mag};
		end else if (state == st_run) begin
			acc <= {partial, acc[`EX_XLEN-1:1]};
		end
	end

	assign full = neg_q ? -acc : acc;

	always_comb begin
		if (ctrl_q.word)
			product = {{(`EX_XLEN-word_w){full[word_w-1]}}, full[word_w-1:0]};
		else if (ctrl_q.high)
			product = full[2*`EX_XLEN-1:`EX_XLEN];
		else
			product = full[`EX_XLEN-1:0];
	end

	assign done = (state == st_finish);

	// ex_ctrl holds off a new multiply until done
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> state == st_idle);

endmodule

/* ex_ctrl.sv */
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_ctrl (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input ex_stage_pkg::ex_in_t in_data,
	output logic in_ready,
	input logic out_ready,
	output logic out_valid,
	output ex_stage_pkg::ex_out_t out_data,
	input logic [`EX_XLEN-1:0] alu_result,
	output logic mul_start,
	input logic mul_done,
	input logic [`EX_XLEN-1:0] mul_result,
	output ex_stage_pkg::branch_t branch
);
	import ex_op_pkg::*;
	import ex_stage_pkg::*;

	logic accept;
	logic is_mul;
	logic mul_busy;
	ex_in_t parked; // multiply payload waiting for its product
	logic [`EX_XLEN-1:0] imm_ext;

	function automatic ex_out_t pack_out(input ex_in_t d, input logic [`EX_XLEN-1:0] res);
		ex_out_t o;
		o.pc = d.pc;
		o.ins = d.ins;
		o.mem_w_en = d.mem_w_en;
		o.wb_sel = d.wb_sel;
		o.reg_w_en = d.reg_w_en;
		o.rt_data = d.rt_data;
		o.rdest = d.rdest;
		o.result = res;
		return o;
	endfunction

	assign is_mul = is_mul_op(in_data.op);
	assign in_ready = !mul_busy && (!out_valid || out_ready);
	assign accept = in_valid && in_ready;
	assign mul_start = accept && is_mul;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			mul_busy <= 1'b0;
		end else begin
			if (mul_done)
				out_valid <= 1'b1;
			else if (accept && !is_mul)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;

			if (mul_start)
				mul_busy <= 1'b1;
			else if (mul_done)
				mul_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_start)
			parked <= in_data;
		if (mul_done)
			out_data <= pack_out(parked, mul_result);
		else if (accept && !is_mul)
			out_data <= pack_out(in_data, alu_result);
	end

	// imm[12:1] sign extended with a zero lsb
	assign imm_ext = {{(`EX_XLEN-`EX_BIMM_W-1){in_data.bimm[`EX_BIMM_W]}}, in_data.bimm, 1'b0};

	always_comb begin
		branch.taken = accept && in_data.brch && (|alu_result);
		branch.bubble = accept && (in_data.ins[6:0] == `EX_OPC_BRANCH);
		branch.target = accept ? in_data.pc + imm_ext : '0;
	end

	// memory stage may sample late
	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* ex_stage.sv */
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_stage (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input ex_stage_pkg::ex_in_t in_data,
	output logic in_ready,
	output logic out_valid,
	output ex_stage_pkg::ex_out_t out_data,
	input logic out_ready,
	output ex_stage_pkg::branch_t branch
);
	import ex_op_pkg::*;

	logic [`EX_XLEN-1:0] alu_result;
	logic mul_start;
	logic mul_done;
	logic [`EX_XLEN-1:0] mul_result;

	ex_alu u_alu (
		.op(in_data.op),
		.src_a(in_data.src_a),
		.src_b(in_data.src_b),
		.alu_result(alu_result)
	);

	// operands are sampled in the accept cycle
	ex_mul u_mul (
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.ctrl(mul_decode(in_data.op)),
		.mul_a(in_data.src_a),
		.mul_b(in_data.src_b),
		.done(mul_done),
		.product(mul_result)
	);

	ex_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.alu_result(alu_result),
		.mul_start(mul_start),
		.mul_done(mul_done),
		.mul_result(mul_result),
		.branch(branch)
	);

endmodule

/* tb_ex_stage.sv */
`timescale 1ns/1ns
`include "ex_settings.svh"

module tb_ex_stage;
	import ex_op_pkg::*;
	import ex_stage_pkg::*;

	localparam int n_alu = 300;
	localparam int n_mul = 40;
	localparam int n_bp = 80;
	// worst case per item plus stall stretches and a margin
	localparam int timeout_cycles = n_alu * 6 + n_mul * (`EX_MUL_CYCLES + 6)
		+ n_bp * (`EX_MUL_CYCLES + 16) + 1000;

	logic clk;
	logic reset;
	logic in_valid;
	ex_in_t in_data;
	logic in_ready;
	logic out_valid;
	ex_out_t out_data;
	logic out_ready;
	branch_t branch;

	ex_out_t exp_q[$]; // accepted items in order
	ex_out_t prev_out;
	logic prev_hold;
	logic mul_wait;
	logic seen_accept;
	logic accepted_last;
	string test_name;
	int ready_mode; // 0 random, 1 long stalls, 2 always ready
	int hold_cnt;
	int cycle_count = 0;

	ex_stage dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready),
		.branch(branch)
	);

	always #5 clk = ~clk;

	function automatic logic [`EX_XLEN-1:0] sx32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic logic [`EX_XLEN-1:0] alu_model(input logic [4:0] op,
			input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
		longint sa;
		longint sb;
		int wa;
		int wb;
		sa = a;
		sb = b;
		wa = a[31:0];
		wb = b[31:0];
		case (op)
			5'd0: return a + b;
			5'd1: return sx32(wa + wb);
			5'd2: return a << b[5:0];
			5'd3: return sx32(a[31:0] << b[4:0]);
			5'd4: return sa >>> b[5:0];
			5'd5: return sx32(wa >>> b[4:0]);
			5'd6: return a >> b[5:0];
			5'd7: return sx32(a[31:0] >> b[4:0]);
			5'd8: return a & b;
			5'd9: return a | b;
			5'd10: return a ^ b;
			5'd11: return (sa < sb) ? 64'd1 : 64'd0;
			5'd12: return (a < b) ? 64'd1 : 64'd0;
			5'd13: return (a == b) ? 64'd1 : 64'd0;
			5'd14: return (a != b) ? 64'd1 : 64'd0;
			5'd15: return (sa >= sb) ? 64'd1 : 64'd0;
			5'd16: return (a >= b) ? 64'd1 : 64'd0;
			5'd17: return a - b;
			5'd18: return sx32(wa - wb);
			default: return 64'd0;
		endcase
	endfunction

	function automatic logic [`EX_XLEN-1:0] mul_model(input logic [4:0] op,
			input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
		logic [127:0] p_ss;
		logic [127:0] p_uu;
		p_ss = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
		p_uu = {64'd0, a} * {64'd0, b};
		case (op)
			5'd19: return p_uu[63:0];
			5'd20: return p_ss[127:64];
			5'd21: return p_uu[127:64];
			default: return sx32(p_uu[31:0]); // low word same for any sign
		endcase
	endfunction

	function automatic ex_out_t expect_out(input ex_in_t d);
		ex_out_t o;
		o.pc = d.pc;
		o.ins = d.ins;
		o.mem_w_en = d.mem_w_en;
		o.wb_sel = d.wb_sel;
		o.reg_w_en = d.reg_w_en;
		o.rt_data = d.rt_data;
		o.rdest = d.rdest;
		if (d.op >= 5'd19)
			o.result = mul_model(d.op, d.src_a, d.src_b);
		else
			o.result = alu_model(d.op, d.src_a, d.src_b);
		return o;
	endfunction

	function automatic logic [`EX_XLEN-1:0] pick_operand();
		int kind;
		kind = $urandom_range(0, 7);
		case (kind)
			0: return '0;
			1: return '1;
			2: return {1'b1, {(`EX_XLEN-1){1'b0}}};
			3: return 64'($urandom_range(0, 70)); // small, for shift amounts
			default: return {$urandom, $urandom};
		endcase
	endfunction

	task automatic report_mismatch(input string what, input string exp_v, input string act_v);
		$display("Mismatch in %s (%s): expected %s, actual %s", test_name, what, exp_v, act_v);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		$display("%s: %s", test_name, msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic send_item(input logic [4:0] op_code);
		ex_in_t d;
		d.pc = {$urandom, $urandom};
		d.ins = $urandom;
		if ($urandom_range(0, 1) == 0)
			d.ins[6:0] = `EX_OPC_BRANCH;
		d.op = ex_op_e'(op_code);
		d.src_a = pick_operand();
		d.src_b = pick_operand();
		d.rt_data = {$urandom, $urandom};
		d.brch = 1'($urandom);
		d.bimm = `EX_BIMM_W'($urandom);
		d.mem_w_en = 1'($urandom);
		d.wb_sel = 1'($urandom);
		d.reg_w_en = 1'($urandom);
		d.rdest = `EX_REG_AW'($urandom);
		in_data = d;
		in_valid = 1'b1;
		do @(negedge clk); while (!accepted_last);
		if ($urandom_range(0, 3) == 0) begin
			in_valid = 1'b0; // idle gap
			@(negedge clk);
		end
	endtask

	task automatic run_items(input int count, input int op_lo, input int op_hi,
			input logic rand_op);
		int i;
		for (i = 0; i < count; i++) begin
			if (rand_op)
				send_item(5'($urandom_range(op_lo, op_hi)));
			else
				send_item(5'(op_lo + i % (op_hi - op_lo + 1))); // every op in turn
		end
	endtask

	always @(negedge clk) begin
		if (ready_mode == 2) begin
			out_ready = 1'b1;
		end else if (ready_mode == 1) begin
			if (hold_cnt > 0) begin
				hold_cnt--;
				out_ready = 1'b0;
			end else if ($urandom_range(0, 2) == 0) begin
				hold_cnt = $urandom_range(1, 8);
				out_ready = 1'b0;
			end else begin
				out_ready = 1'b1;
			end
		end else begin
			out_ready = ($urandom_range(0, 7) != 0);
		end
	end

	always @(posedge clk) begin : monitor
		ex_out_t head;
		logic acc;
		logic [`EX_XLEN-1:0] exp_target;
		longint imm_off;
		logic exp_taken;
		logic exp_bubble;
		acc = in_valid && in_ready;
		accepted_last = 1'b0;
		if (reset) begin
			prev_hold = 1'b0;
			mul_wait = 1'b0;
		end else begin
			if (!seen_accept) begin
				a_reset_idle: assert (!out_valid)
					else report_failure("out_valid high before any input was accepted");
			end
			if (prev_hold) begin
				a_hold_valid: assert (out_valid)
					else report_failure("out_valid dropped while out_ready was low");
				a_hold_data: assert (out_data == prev_out)
					else report_mismatch("held out_data", $sformatf("%h", prev_out),
						$sformatf("%h", out_data));
			end
			a_full_stall: assert (!(out_valid && !out_ready && in_ready))
				else report_failure("in_ready high while the output register is stalled");
			if (mul_wait) begin
				if (out_valid) begin
					mul_wait = 1'b0;
				end else begin
					a_mul_block: assert (!in_ready)
						else report_failure("in_ready high while a multiply is running");
				end
			end
			if (out_valid && out_ready) begin
				a_expected: assert (exp_q.size() != 0)
					else report_failure("output transfer without an accepted input");
				if (exp_q.size() != 0) begin
					head = exp_q.pop_front();
					a_out: assert (out_data == head)
						else report_mismatch("out_data", $sformatf("%h", head),
							$sformatf("%h", out_data));
				end
			end
			if (acc) begin
				imm_off = $signed(in_data.bimm); // offset in half words
				exp_target = in_data.pc + imm_off * 2;
				exp_taken = in_data.brch
					&& (alu_model(in_data.op, in_data.src_a, in_data.src_b) != '0);
				exp_bubble = (in_data.ins[6:0] == `EX_OPC_BRANCH);
				a_target: assert (branch.target == exp_target)
					else report_mismatch("branch target", $sformatf("%h", exp_target),
						$sformatf("%h", branch.target));
				a_taken: assert (branch.taken == exp_taken)
					else report_mismatch("branch taken", $sformatf("%b", exp_taken),
						$sformatf("%b", branch.taken));
				a_bubble: assert (branch.bubble == exp_bubble)
					else report_mismatch("branch bubble", $sformatf("%b", exp_bubble),
						$sformatf("%b", branch.bubble));
				exp_q.push_back(expect_out(in_data));
				if (in_data.op >= 5'd19)
					mul_wait = 1'b1;
				seen_accept = 1'b1;
				accepted_last = 1'b1;
			end else begin
				a_quiet: assert (!branch.taken && !branch.bubble)
					else report_failure("branch taken or bubble outside an accept cycle");
			end
			prev_hold = out_valid && !out_ready;
			prev_out = out_data;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	end

	initial begin
		void'($urandom(32'hf7024859));
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		ready_mode = 2;
		hold_cnt = 0;
		seen_accept = 1'b0;
		accepted_last = 1'b0;
		prev_hold = 1'b0;
		mul_wait = 1'b0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);
		test_name = "alu";
		ready_mode = 0;
		run_items(n_alu, 0, 18, 1'b0);
		test_name = "mul";
		run_items(n_mul, 19, 22, 1'b0);
		test_name = "backpressure";
		ready_mode = 1;
		run_items(n_bp, 0, 22, 1'b1);
		in_valid = 1'b0;
		test_name = "drain";
		ready_mode = 2;
		// stage is empty once no multiply runs and the register has drained
		while (out_valid || mul_wait)
			@(negedge clk);
		if (exp_q.size() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("drain: %0d accepted items never left the stage", exp_q.size());
			$display("ERRORS FOUND");
			$fatal(1);
		end
	end

endmodule

/* project.f */
+incdir+.
ex_op_pkg.sv
ex_stage_pkg.sv
ex_alu.sv
ex_mul.sv
ex_ctrl.sv
ex_stage.sv
tb_ex_stage.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_ex_stage \
	-Mdir obj_dir -o tb_ex_stage -f project.f > build.log 2>&1 &&
./obj_dir/tb_ex_stage > sim.log 2>&1
cat build.log
[ -f sim.log ] && cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } ||
	grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
